// ==== verilog/core_pkg.sv ====
// widths, reset vector and decode enums shared by the rv64 pipeline, imported by each rtl unit
package core_pkg;
	localparam int xlen = 64;
	localparam int reg_addr_w = 5;
	localparam logic [xlen-1:0] pc_start = 64'h8000_0000;

	// major opcodes seen by the decoder
	typedef enum logic [6:0] {
		op_load   = 7'h03,
		op_imm    = 7'h13,
		op_store  = 7'h23,
		op_reg    = 7'h33,
		op_branch = 7'h63,
		op_trap   = 7'h6b,
		op_jal    = 7'h6f
	} opcode_t;

	typedef enum logic [3:0] {
		uop_nop,
		uop_alu,
		uop_alui,
		uop_load,
		uop_store,
		uop_beq,
		uop_bne,
		uop_jal,
		uop_trap
	} uop_t;

	typedef enum logic [2:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_xor
	} alu_op_t;

	// operand source in execute
	typedef enum logic [1:0] {
		fwd_reg,
		fwd_mem,
		fwd_wb
	} fwd_sel_t;
endpackage

// ==== verilog/dec_bus.sv ====
// decoded instruction bundle from decode to execute, also watched by the hazard logic
`timescale 1ns/10ps

interface dec_bus;
	import core_pkg::*;

	logic valid;
	uop_t uop;
	alu_op_t alu_op;
	logic [xlen-1:0] pc;
	logic [reg_addr_w-1:0] rs1_addr;
	logic [reg_addr_w-1:0] rs2_addr;
	logic [xlen-1:0] rs1_data;
	logic [xlen-1:0] rs2_data;
	logic [xlen-1:0] imm;
	logic [reg_addr_w-1:0] rd_addr;

	modport producer (
		output valid, uop, alu_op, pc, rs1_addr, rs2_addr, rs1_data, rs2_data, imm, rd_addr
	);
	modport consumer (
		input valid, uop, alu_op, pc, rs1_addr, rs2_addr, rs1_data, rs2_data, imm, rd_addr
	);
	// hazard logic only needs the register fields
	modport watch (input uop, rd_addr, rs1_addr, rs2_addr);
endinterface

// ==== verilog/fetch_unit.sv ====
// fetch stage, owns the pc and the fetch/decode register, instantiated by core_top
`timescale 1ns/10ps

module fetch_unit (
	input  logic clock,
	input  logic reset,
	input  logic stall,
	input  logic redirect,
	input  logic [core_pkg::xlen-1:0] target,
	input  logic halted,
	output logic [core_pkg::xlen-1:0] inst_addr,
	input  logic [31:0] inst_data,
	output logic id_valid,
	output logic [31:0] id_inst,
	output logic [core_pkg::xlen-1:0] id_pc
);
	import core_pkg::*;

	logic [xlen-1:0] pc;
	logic [xlen-1:0] pc_next;

	// halt freezes, a redirect beats the load-use hold
	always_comb begin
		if (halted)
			pc_next = pc;
		else if (redirect)
			pc_next = target;
		else if (stall)
			pc_next = pc;
		else
			pc_next = pc + 64'd4;
	end

	assign inst_addr = pc;

	always_ff @(posedge clock) begin
		if (reset)
			pc <= pc_start;
		else
			pc <= pc_next;
	end

	always_ff @(posedge clock) begin
		if (reset || redirect)
			id_valid <= 1'b0;
		else if (!stall)
			id_valid <= 1'b1;
	end

	always_ff @(posedge clock) begin
		if (!stall) begin
			id_inst <= inst_data;
			id_pc <= pc;
		end
	end

	// pc only ever moves in whole words
	assert property (@(posedge clock) disable iff (reset) pc[1:0] == 2'b00);
endmodule

// ==== verilog/decoder.sv ====
// decode stage, cracks an instruction word and registers it into the execute bundle
`timescale 1ns/10ps

module decoder (
	input  logic clock,
	input  logic reset,
	input  logic id_valid,
	input  logic [31:0] id_inst,
	input  logic [core_pkg::xlen-1:0] id_pc,
	input  logic stall,
	input  logic flush,
	output logic [core_pkg::reg_addr_w-1:0] rs1_addr,
	output logic [core_pkg::reg_addr_w-1:0] rs2_addr,
	input  logic [core_pkg::xlen-1:0] rs1_data,
	input  logic [core_pkg::xlen-1:0] rs2_data,
	dec_bus.producer ex
);
	import core_pkg::*;

	logic [2:0] funct3;
	logic [6:0] funct7;
	uop_t uop;
	alu_op_t alu_op;
	logic [xlen-1:0] imm;
	logic use_rs1;
	logic use_rs2;
	logic writes_rd;
	logic [reg_addr_w-1:0] rd_addr;

	assign funct3 = id_inst[14:12];
	assign funct7 = id_inst[31:25];

	always_comb begin
		uop = uop_nop;
		alu_op = alu_add;
		imm = {{52{id_inst[31]}}, id_inst[31:20]};
		case (id_inst[6:0])
			op_reg: begin
				uop = uop_alu;
				case ({funct7, funct3})
					{7'h00, 3'b000}: alu_op = alu_add;
					{7'h20, 3'b000}: alu_op = alu_sub;
					{7'h00, 3'b100}: alu_op = alu_xor;
					{7'h00, 3'b110}: alu_op = alu_or;
					{7'h00, 3'b111}: alu_op = alu_and;
					default: uop = uop_nop;
				endcase
			end
			op_imm: begin
				if (funct3 == 3'b000)
					uop = uop_alui;
			end
			op_load: begin
				if (funct3 == 3'b011)
					uop = uop_load;
			end
			op_store: begin
				imm = {{52{id_inst[31]}}, id_inst[31:25], id_inst[11:7]};
				if (funct3 == 3'b011)
					uop = uop_store;
			end
			op_branch: begin
				imm = {{51{id_inst[31]}}, id_inst[31], id_inst[7], id_inst[30:25],
					id_inst[11:8], 1'b0};
				if (funct3 == 3'b000)
					uop = uop_beq;
				else if (funct3 == 3'b001)
					uop = uop_bne;
			end
			op_jal: begin
				uop = uop_jal;
				imm = {{43{id_inst[31]}}, id_inst[31], id_inst[19:12], id_inst[20],
					id_inst[30:21], 1'b0};
			end
			op_trap: uop = uop_trap;
			default: uop = uop_nop;
		endcase
		if (!id_valid)
			uop = uop_nop;
	end

	// unused sources read as x0 so they never stall or forward
	assign use_rs1 = uop inside {uop_alu, uop_alui, uop_load, uop_store, uop_beq, uop_bne};
	assign use_rs2 = uop inside {uop_alu, uop_store, uop_beq, uop_bne};
	assign writes_rd = uop inside {uop_alu, uop_alui, uop_load, uop_jal};
	assign rs1_addr = use_rs1 ? id_inst[19:15] : '0;
	assign rs2_addr = use_rs2 ? id_inst[24:20] : '0;
	assign rd_addr = writes_rd ? id_inst[11:7] : '0;

	always_ff @(posedge clock) begin
		if (reset || stall || flush) begin
			ex.valid <= 1'b0;
			ex.uop <= uop_nop;
			ex.rd_addr <= '0;
			ex.rs1_addr <= '0;
			ex.rs2_addr <= '0;
		end else begin
			ex.valid <= id_valid;
			ex.uop <= uop;
			ex.rd_addr <= rd_addr;
			ex.rs1_addr <= rs1_addr;
			ex.rs2_addr <= rs2_addr;
		end
	end

	always_ff @(posedge clock) begin
		ex.alu_op <= alu_op;
		ex.pc <= id_pc;
		ex.rs1_data <= rs1_data;
		ex.rs2_data <= rs2_data;
		ex.imm <= imm;
	end
endmodule

// ==== verilog/regfile.sv ====
// integer register file, read in decode and written from writeback with write-through
`timescale 1ns/10ps

module regfile (
	input  logic clock,
	input  logic reset,
	input  logic [core_pkg::reg_addr_w-1:0] raddr1,
	input  logic [core_pkg::reg_addr_w-1:0] raddr2,
	output logic [core_pkg::xlen-1:0] rdata1,
	output logic [core_pkg::xlen-1:0] rdata2,
	input  logic wen,
	input  logic [core_pkg::reg_addr_w-1:0] waddr,
	input  logic [core_pkg::xlen-1:0] wdata
);
	import core_pkg::*;

	logic [xlen-1:0] regs [1:31];

	function automatic logic [xlen-1:0] read_port(input logic [reg_addr_w-1:0] addr);
		if (addr == '0)
			return '0;
		// same-cycle writeback wins
		if (wen && waddr == addr)
			return wdata;
		return regs[addr];
	endfunction

	always_comb begin
		rdata1 = read_port(raddr1);
		rdata2 = read_port(raddr2);
	end

	always_ff @(posedge clock) begin
		if (wen && waddr != '0)
			regs[waddr] <= wdata;
	end

	// writeback drops x0 writes before they get here
	assert property (@(posedge clock) disable iff (reset) wen |-> waddr != '0);
endmodule

// ==== verilog/hazard_forward.sv ====
// load-use stall, redirect flush and operand forwarding selects for the execute stage
`timescale 1ns/10ps

module hazard_forward (
	input  logic [core_pkg::reg_addr_w-1:0] id_rs1,
	input  logic [core_pkg::reg_addr_w-1:0] id_rs2,
	dec_bus.watch ex,
	input  logic [core_pkg::reg_addr_w-1:0] me_rd,
	input  logic [core_pkg::reg_addr_w-1:0] wb_rd,
	input  logic me_wen,
	input  logic wb_wen,
	input  logic taken,
	output logic stall,
	output logic flush,
	output core_pkg::fwd_sel_t rs1_sel,
	output core_pkg::fwd_sel_t rs2_sel
);
	import core_pkg::*;

	// youngest producer first
	function automatic fwd_sel_t pick(input logic [reg_addr_w-1:0] src);
		if (me_wen && me_rd == src)
			return fwd_mem;
		if (wb_wen && wb_rd == src)
			return fwd_wb;
		return fwd_reg;
	endfunction

	assign flush = taken;

	// load data only exists once the load reaches writeback
	assign stall = ex.uop == uop_load && ex.rd_addr != '0 &&
		(ex.rd_addr == id_rs1 || ex.rd_addr == id_rs2);

	always_comb begin
		rs1_sel = pick(ex.rs1_addr);
		rs2_sel = pick(ex.rs2_addr);
	end

	// a load in execute never resolves as taken
	always_comb begin
		assert (!(stall && flush))
			else $error("load-use stall while execute redirects");
	end
endmodule

// ==== verilog/execute_unit.sv ====
// execute stage, alu with forwarded operands plus branch decision and target
`timescale 1ns/10ps

module execute_unit (
	dec_bus.consumer ex,
	input  core_pkg::fwd_sel_t rs1_sel,
	input  core_pkg::fwd_sel_t rs2_sel,
	input  logic [core_pkg::xlen-1:0] me_result,
	input  logic [core_pkg::xlen-1:0] wb_data,
	output logic [core_pkg::xlen-1:0] result,
	output logic [core_pkg::xlen-1:0] store_data,
	output logic [core_pkg::xlen-1:0] target,
	output logic taken
);
	import core_pkg::*;

	logic [xlen-1:0] op1;
	logic [xlen-1:0] op2;
	logic [xlen-1:0] alu_b;
	logic [xlen-1:0] alu_out;

	function automatic logic [xlen-1:0] pick(input fwd_sel_t sel, input logic [xlen-1:0] reg_val);
		case (sel)
			fwd_mem: return me_result;
			fwd_wb: return wb_data;
			default: return reg_val;
		endcase
	endfunction

	always_comb begin
		op1 = pick(rs1_sel, ex.rs1_data);
		op2 = pick(rs2_sel, ex.rs2_data);
	end

	// loads and stores add the immediate for the address
	assign alu_b = (ex.uop == uop_alu) ? op2 : ex.imm;

	always_comb begin
		case (ex.alu_op)
			alu_sub: alu_out = op1 - alu_b;
			alu_and: alu_out = op1 & alu_b;
			alu_or: alu_out = op1 | alu_b;
			alu_xor: alu_out = op1 ^ alu_b;
			default: alu_out = op1 + alu_b;
		endcase
	end

	// jal links pc+4
	assign result = (ex.uop == uop_jal) ? ex.pc + 64'd4 : alu_out;
	assign store_data = op2;
	assign target = ex.pc + ex.imm;

	assign taken = ex.valid && ((ex.uop == uop_beq && op1 == op2) ||
		(ex.uop == uop_bne && op1 != op2) || ex.uop == uop_jal);
endmodule

// ==== verilog/core_top.sv ====
// top of the five-stage rv64 core, memory ports and the commit port go to the testbench
`timescale 1ns/10ps

module core_top (
	input  logic clock,
	input  logic reset,
	output logic [core_pkg::xlen-1:0] inst_addr,
	input  logic [31:0] inst_data,
	output logic [core_pkg::xlen-1:0] data_addr,
	output logic [core_pkg::xlen-1:0] data_wdata,
	output logic data_wen,
	output logic data_ren,
	input  logic [core_pkg::xlen-1:0] data_rdata,
	output logic commit_valid,
	output logic [core_pkg::xlen-1:0] commit_pc,
	output logic [core_pkg::reg_addr_w-1:0] commit_rd,
	output logic [core_pkg::xlen-1:0] commit_wdata,
	output logic halted
);
	import core_pkg::*;

	logic stall;
	logic flush;
	logic taken;
	logic [xlen-1:0] target;
	logic id_valid;
	logic [31:0] id_inst;
	logic [xlen-1:0] id_pc;
	logic [reg_addr_w-1:0] id_rs1;
	logic [reg_addr_w-1:0] id_rs2;
	logic [xlen-1:0] rs1_data;
	logic [xlen-1:0] rs2_data;
	fwd_sel_t rs1_sel;
	fwd_sel_t rs2_sel;
	logic [xlen-1:0] ex_result;
	logic [xlen-1:0] ex_store_data;

	// memory stage
	logic me_valid;
	uop_t me_uop;
	logic [reg_addr_w-1:0] me_rd;
	logic [xlen-1:0] me_result;
	logic [xlen-1:0] me_store_data;
	logic [xlen-1:0] me_pc;
	logic me_wen;

	// writeback stage
	logic wb_valid;
	logic wb_trap;
	logic [reg_addr_w-1:0] wb_rd;
	logic [xlen-1:0] wb_data;
	logic [xlen-1:0] wb_pc;
	logic wb_wen;

	dec_bus ex_bus ();

	fetch_unit fetch0 (
		.clock(clock), .reset(reset), .stall(stall), .redirect(taken), .target(target),
		.halted(halted), .inst_addr(inst_addr), .inst_data(inst_data),
		.id_valid(id_valid), .id_inst(id_inst), .id_pc(id_pc)
	);

	decoder decode0 (
		.clock(clock), .reset(reset), .id_valid(id_valid), .id_inst(id_inst), .id_pc(id_pc),
		.stall(stall), .flush(flush), .rs1_addr(id_rs1), .rs2_addr(id_rs2),
		.rs1_data(rs1_data), .rs2_data(rs2_data), .ex(ex_bus)
	);

	regfile regs0 (
		.clock(clock), .reset(reset), .raddr1(id_rs1), .raddr2(id_rs2),
		.rdata1(rs1_data), .rdata2(rs2_data), .wen(wb_wen), .waddr(wb_rd), .wdata(wb_data)
	);

	hazard_forward hazard0 (
		.id_rs1(id_rs1), .id_rs2(id_rs2), .ex(ex_bus), .me_rd(me_rd), .wb_rd(wb_rd),
		.me_wen(me_wen), .wb_wen(wb_wen), .taken(taken), .stall(stall), .flush(flush),
		.rs1_sel(rs1_sel), .rs2_sel(rs2_sel)
	);

	execute_unit exec0 (
		.ex(ex_bus), .rs1_sel(rs1_sel), .rs2_sel(rs2_sel), .me_result(me_result),
		.wb_data(wb_data), .result(ex_result), .store_data(ex_store_data),
		.target(target), .taken(taken)
	);

	always_ff @(posedge clock) begin
		if (reset) begin
			me_valid <= 1'b0;
			me_uop <= uop_nop;
			me_rd <= '0;
		end else begin
			me_valid <= ex_bus.valid;
			me_uop <= ex_bus.uop;
			me_rd <= ex_bus.rd_addr;
		end
	end

	always_ff @(posedge clock) begin
		me_result <= ex_result;
		me_store_data <= ex_store_data;
		me_pc <= ex_bus.pc;
	end

	assign me_wen = me_valid && me_rd != '0;
	assign data_addr = me_result;
	assign data_wdata = me_store_data;
	assign data_ren = me_valid && me_uop == uop_load;
	// nothing younger than a retiring trap may touch memory
	assign data_wen = me_valid && me_uop == uop_store && !halted && !(wb_valid && wb_trap);

	always_ff @(posedge clock) begin
		if (reset) begin
			wb_valid <= 1'b0;
			wb_trap <= 1'b0;
			wb_rd <= '0;
		end else begin
			wb_valid <= me_valid;
			wb_trap <= me_valid && me_uop == uop_trap;
			wb_rd <= me_rd;
		end
	end

	always_ff @(posedge clock) begin
		wb_data <= data_ren ? data_rdata : me_result;
		wb_pc <= me_pc;
	end

	// sticky until reset
	always_ff @(posedge clock) begin
		if (reset)
			halted <= 1'b0;
		else if (wb_valid && wb_trap)
			halted <= 1'b1;
	end

	assign wb_wen = wb_valid && wb_rd != '0 && !halted;

	assign commit_valid = wb_valid && !halted;
	assign commit_pc = wb_pc;
	assign commit_rd = wb_rd;
	assign commit_wdata = (wb_rd != '0) ? wb_data : '0;
endmodule

// ==== tb/core_tb.sv ====
// testbench for core_top, builds a program, runs a reference model and checks every commit
`timescale 1ns/10ps

module core_tb;
	import core_pkg::*;

	localparam int imem_words = 256;
	localparam int dmem_words = 64;
	localparam int cycles_per_inst = 20;

	logic clock;
	logic reset;
	logic [xlen-1:0] inst_addr;
	logic [31:0] inst_data;
	logic [xlen-1:0] data_addr;
	logic [xlen-1:0] data_wdata;
	logic data_wen;
	logic data_ren;
	logic [xlen-1:0] data_rdata;
	logic commit_valid;
	logic [xlen-1:0] commit_pc;
	logic [reg_addr_w-1:0] commit_rd;
	logic [xlen-1:0] commit_wdata;
	logic halted;

	logic [31:0] imem [0:imem_words-1];
	int sect [0:imem_words-1];
	logic [xlen-1:0] dmem [0:dmem_words-1];
	int n_inst;
	int cur_section;
	int program_len = 0;
	logic [31:0] lfsr;
	string test_names [0:5];

	// expected commit records, oldest first
	logic [xlen-1:0] exp_pc [$];
	logic [reg_addr_w-1:0] exp_rd [$];
	logic [xlen-1:0] exp_wdata [$];
	int exp_test [$];

	core_top dut0 (
		.clock(clock), .reset(reset), .inst_addr(inst_addr), .inst_data(inst_data),
		.data_addr(data_addr), .data_wdata(data_wdata), .data_wen(data_wen),
		.data_ren(data_ren), .data_rdata(data_rdata), .commit_valid(commit_valid),
		.commit_pc(commit_pc), .commit_rd(commit_rd), .commit_wdata(commit_wdata),
		.halted(halted)
	);

	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("** FAIL **");
		$fatal(1, "simulation stopped on error");
	endtask

	task automatic compare_addr(input string test, input string what,
		input logic [xlen-1:0] expected, input logic [xlen-1:0] actual);
		if (actual !== expected) begin
			$display("MISMATCH %s: %s expected %h actual %h", test, what, expected, actual);
			abort_run("address check failed");
		end
	endtask

	task automatic compare_data(input string test, input logic [xlen-1:0] expected,
		input logic [xlen-1:0] actual);
		if (actual !== expected) begin
			$display("MISMATCH %s: wdata expected %h actual %h", test, expected, actual);
			abort_run("write data check failed");
		end
	endtask

	task automatic compare_rd(input string test, input logic [reg_addr_w-1:0] expected,
		input logic [reg_addr_w-1:0] actual);
		if (actual !== expected) begin
			$display("MISMATCH %s: rd expected %0d actual %0d", test, expected, actual);
			abort_run("destination register check failed");
		end
	endtask

	task automatic compare_flag(input string test, input string what, input logic expected,
		input logic actual);
		if (actual !== expected) begin
			$display("MISMATCH %s: %s expected %b actual %b", test, what, expected, actual);
			abort_run("status flag check failed");
		end
	endtask

	// taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic int random_bits(input int n);
		int v;
		v = 0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v = v * 2 + int'(lfsr[0]);
		end
		return v;
	endfunction

	function automatic logic [xlen-1:0] fill_value(input int idx);
		return {16'hc0de, 16'(idx), 32'(idx) * 32'h9e37_79b9};
	endfunction

	// doubleword index, wraps inside the small data array
	function automatic int dmem_index(input logic [xlen-1:0] addr);
		return int'(addr[8:3]);
	endfunction

	function automatic logic [31:0] fetch_word(input logic [xlen-1:0] addr);
		logic [xlen-1:0] offset;
		offset = addr - pc_start;
		if (offset < 64'(imem_words * 4) && offset[1:0] == 2'b00)
			return imem[int'(offset[9:2])];
		return 32'h0000_0013;
	endfunction

	function automatic logic [31:0] alu_r(input alu_op_t op, input int rd, rs1, rs2);
		logic [6:0] f7;
		logic [2:0] f3;
		f7 = (op == alu_sub) ? 7'h20 : 7'h00;
		case (op)
			alu_and: f3 = 3'h7;
			alu_or: f3 = 3'h6;
			alu_xor: f3 = 3'h4;
			default: f3 = 3'h0;
		endcase
		return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), 7'h33};
	endfunction

	function automatic logic [31:0] addi_i(input int rd, rs1, imm);
		return {12'(imm), 5'(rs1), 3'h0, 5'(rd), 7'h13};
	endfunction

	function automatic logic [31:0] load_i(input int rd, rs1, imm);
		return {12'(imm), 5'(rs1), 3'h3, 5'(rd), 7'h03};
	endfunction

	function automatic logic [31:0] store_s(input int rs2, rs1, imm);
		logic [11:0] v;
		v = 12'(imm);
		return {v[11:5], 5'(rs2), 5'(rs1), 3'h3, v[4:0], 7'h23};
	endfunction

	function automatic logic [31:0] branch_b(input logic bne, input int rs1, rs2, off);
		logic [12:0] v;
		v = 13'(off);
		return {v[12], v[10:5], 5'(rs2), 5'(rs1), {2'b00, bne}, v[4:1], v[11], 7'h63};
	endfunction

	function automatic logic [31:0] jal_j(input int rd, off);
		logic [20:0] v;
		v = 21'(off);
		return {v[20], v[10:1], v[11], v[19:12], 5'(rd), 7'h6f};
	endfunction

	task automatic put_inst(input logic [31:0] word);
		imem[n_inst] = word;
		sect[n_inst] = cur_section;
		n_inst++;
	endtask

	task automatic build_program();
		int kind;
		int rd;
		int rs1;
		int rs2;
		int imm;
		for (int i = 0; i < imem_words; i++)
			imem[i] = 32'h0000_0013;
		n_inst = 0;
		// every register that is read later gets a value first
		cur_section = 0;
		for (int i = 1; i < 15; i++)
			put_inst(addi_i(i, 0, i * 37 - 300));
		put_inst(addi_i(15, 0, 64));
		cur_section = 1;
		put_inst(alu_r(alu_add, 3, 1, 2));
		put_inst(alu_r(alu_add, 4, 3, 1));
		put_inst(alu_r(alu_sub, 5, 4, 3));
		put_inst(alu_r(alu_xor, 6, 5, 4));
		put_inst(addi_i(6, 6, -5));
		put_inst(alu_r(alu_and, 7, 6, 5));
		put_inst(alu_r(alu_or, 8, 7, 6));
		put_inst(addi_i(8, 8, 100));
		put_inst(addi_i(8, 8, -1));
		put_inst(alu_r(alu_add, 9, 8, 1));
		put_inst(addi_i(2, 0, 3));
		put_inst(alu_r(alu_sub, 9, 9, 8));
		cur_section = 2;
		put_inst(store_s(3, 15, 0));
		put_inst(load_i(11, 15, 0));
		put_inst(alu_r(alu_add, 12, 11, 11));
		put_inst(load_i(13, 15, 8));
		put_inst(store_s(13, 15, 16));
		put_inst(load_i(14, 15, 16));
		put_inst(addi_i(14, 14, 1));
		put_inst(load_i(11, 15, 24));
		put_inst(addi_i(2, 2, 1));
		put_inst(alu_r(alu_xor, 12, 11, 2));
		put_inst(store_s(12, 15, 32));
		put_inst(load_i(13, 15, 32));
		put_inst(alu_r(alu_sub, 14, 13, 12));
		cur_section = 3;
		put_inst(addi_i(1, 0, 5));
		put_inst(addi_i(2, 0, 5));
		put_inst(branch_b(1'b0, 1, 2, 8));
		put_inst(addi_i(3, 0, 111));
		put_inst(branch_b(1'b1, 1, 2, 8));
		put_inst(addi_i(4, 0, 7));
		put_inst(branch_b(1'b1, 1, 4, 12));
		put_inst(addi_i(5, 0, 1));
		put_inst(addi_i(5, 0, 2));
		put_inst(branch_b(1'b0, 1, 4, 8));
		put_inst(jal_j(6, 8));
		put_inst(addi_i(7, 0, 9));
		put_inst(jal_j(0, 8));
		put_inst(addi_i(7, 0, 10));
		put_inst(alu_r(alu_add, 8, 6, 1));
		// branch right behind a load
		put_inst(load_i(9, 15, 0));
		put_inst(branch_b(1'b1, 9, 0, 8));
		put_inst(addi_i(10, 0, 1));
		put_inst(branch_b(1'b0, 9, 9, 8));
		put_inst(addi_i(10, 0, 2));
		put_inst(addi_i(10, 10, 3));
		cur_section = 4;
		put_inst(addi_i(0, 0, 55));
		put_inst(alu_r(alu_add, 0, 1, 2));
		put_inst(alu_r(alu_add, 9, 0, 1));
		put_inst(alu_r(alu_or, 10, 0, 0));
		put_inst(load_i(0, 15, 8));
		put_inst(alu_r(alu_add, 11, 0, 0));
		cur_section = 5;
		for (int i = 0; i < 64; i++) begin
			kind = random_bits(3) % 6;
			rd = random_bits(4);
			rs1 = random_bits(4);
			rs2 = random_bits(4);
			imm = random_bits(12) - 2048;
			if (kind == 5)
				put_inst(addi_i(rd, rs1, imm));
			else
				put_inst(alu_r(alu_op_t'(3'(kind)), rd, rs1, rs2));
		end
		put_inst(32'h0000_006b);
	endtask

	// architectural model, one commit record per retired instruction
	function automatic void run_reference();
		logic [xlen-1:0] x [0:31];
		logic [xlen-1:0] mem [0:dmem_words-1];
		logic [xlen-1:0] pc;
		logic [xlen-1:0] next_pc;
		logic [xlen-1:0] val;
		logic [xlen-1:0] a;
		logic [xlen-1:0] b;
		logic [xlen-1:0] imm_i;
		logic [xlen-1:0] imm_s;
		logic [xlen-1:0] imm_b;
		logic [xlen-1:0] imm_j;
		logic [31:0] w;
		logic [4:0] rd;
		logic wr;
		logic stop;
		int idx;
		int steps;
		for (int i = 0; i < 32; i++)
			x[i] = '0;
		for (int i = 0; i < dmem_words; i++)
			mem[i] = fill_value(i);
		pc = pc_start;
		stop = 1'b0;
		steps = 0;
		while (!stop && steps < imem_words) begin
			idx = int'((pc - pc_start) >> 2);
			w = imem[idx];
			a = x[w[19:15]];
			b = x[w[24:20]];
			rd = w[11:7];
			imm_i = {{52{w[31]}}, w[31:20]};
			imm_s = {{52{w[31]}}, w[31:25], w[11:7]};
			imm_b = {{51{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
			imm_j = {{43{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
			next_pc = pc + 64'd4;
			val = '0;
			wr = 1'b0;
			case (w[6:0])
				7'h33: begin
					wr = 1'b1;
					case ({w[31:25], w[14:12]})
						10'h000: val = a + b;
						10'h100: val = a - b;
						10'h004: val = a ^ b;
						10'h006: val = a | b;
						10'h007: val = a & b;
						default: wr = 1'b0;
					endcase
				end
				7'h13: begin
					wr = 1'b1;
					val = a + imm_i;
				end
				7'h03: begin
					wr = 1'b1;
					val = mem[dmem_index(a + imm_i)];
				end
				7'h23: mem[dmem_index(a + imm_s)] = b;
				7'h63: begin
					if ((w[14:12] == 3'h0 && a == b) || (w[14:12] == 3'h1 && a != b))
						next_pc = pc + imm_b;
				end
				7'h6f: begin
					wr = 1'b1;
					val = pc + 64'd4;
					next_pc = pc + imm_j;
				end
				7'h6b: stop = 1'b1;
				default: wr = 1'b0;
			endcase
			if (!wr)
				rd = '0;
			if (rd != '0)
				x[rd] = val;
			else
				val = '0;
			exp_pc.push_back(pc);
			exp_rd.push_back(rd);
			exp_wdata.push_back(val);
			exp_test.push_back(sect[idx]);
			pc = next_pc;
			steps++;
		end
	endfunction

	// memories answer half a cycle after the address moves
	always @(negedge clock) begin
		if (data_wen === 1'b1)
			dmem[dmem_index(data_addr)] = data_wdata;
		inst_data = fetch_word(inst_addr);
		data_rdata = dmem[dmem_index(data_addr)];
	end

	always @(negedge clock) begin : commit_check
		logic [xlen-1:0] pc_e;
		logic [reg_addr_w-1:0] rd_e;
		logic [xlen-1:0] wdata_e;
		string name;
		if (reset === 1'b0 && commit_valid === 1'b1) begin
			if (exp_pc.size() == 0) begin
				abort_run("commit seen after the last expected instruction");
			end else begin
				pc_e = exp_pc.pop_front();
				rd_e = exp_rd.pop_front();
				wdata_e = exp_wdata.pop_front();
				name = test_names[exp_test.pop_front()];
				compare_addr(name, "commit pc", pc_e, commit_pc);
				compare_rd(name, rd_e, commit_rd);
				compare_data(name, wdata_e, commit_wdata);
			end
		end
	end

	initial begin : watchdog
		wait (program_len > 0);
		repeat (program_len * cycles_per_inst) @(posedge clock);
		abort_run("timeout waiting for the core to halt");
	end

	initial begin
		reset = 1'b1;
		inst_data = 32'h0000_0013;
		data_rdata = '0;
		test_names = '{"setup", "forwarding", "load_store", "branch", "x0_writes", "random_alu"};
		lfsr = 32'h6071bc74;
		for (int i = 0; i < dmem_words; i++)
			dmem[i] = fill_value(i);
		build_program();
		run_reference();
		program_len = n_inst;
		repeat (2) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;
		compare_flag("reset_state", "commit_valid", 1'b0, commit_valid);
		compare_flag("reset_state", "data_wen", 1'b0, data_wen);
		compare_flag("reset_state", "data_ren", 1'b0, data_ren);
		compare_flag("reset_state", "halted", 1'b0, halted);
		compare_addr("reset_state", "inst_addr", pc_start, inst_addr);
		wait (halted === 1'b1);
		// a few more cycles to catch any commit after the halt
		repeat (3) @(negedge clock);
		if (halted === 1'b1 && exp_pc.size() == 0) begin
			$display("** PASS **");
			$finish;
		end else begin
			abort_run("core halted before every expected instruction retired");
		end
	end
endmodule

// ==== all.f ====
verilog/core_pkg.sv
verilog/dec_bus.sv
verilog/fetch_unit.sv
verilog/decoder.sv
verilog/regfile.sv
verilog/hazard_forward.sv
verilog/execute_unit.sv
verilog/core_top.sv
tb/core_tb.sv

// ==== run.sh ====
#!/bin/bash
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module core_tb -f all.f > build.log 2>&1 \
	|| { cat build.log; echo "build failed"; exit 1; }
./obj_dir/Vcore_tb > sim.log 2>&1
cat sim.log
grep -q '\*\* FAIL \*\*' sim.log && exit 1 || grep -q '\*\* PASS \*\*' sim.log
